// File: Bender.yml
package:
  name: colmix

sources:
  - include_dirs:
      - include
    files:
      - hw/colmix_pkg.sv
      - hw/layer_prio.sv
      - hw/pal_ram.sv
      - hw/colour_out.sv
      - hw/colmix_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/colmix_clkgen.sv
      - tb/tb_colmix.sv

// File: hw/colmix_pkg.sv
// Colour mixer shared types
`default_nettype none

`include "colmix_settings.svh"

package colmix_pkg;

    // One layer pixel, index 0 is transparent
    typedef struct packed {
        logic [3:0] bank;
        logic [3:0] idx;
    } layer_pxl_t;

    // Mixer decision for one pixel
    typedef struct packed {
        logic [9:0] entry;
        logic       shadow;
        logic       visible;
    } mix_pxl_t;

    // CPU palette access
    typedef struct packed {
        logic                       we;
        logic [`COLMIX_PAL_AW-1:0] addr;
        logic [7:0]                 data;
    } cpu_bus_t;

    // Palette word, as fetched bytes or as colour fields
    typedef union packed {
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
        struct packed {
            logic       pad;
            logic [4:0] blue;
            logic [4:0] green;
            logic [4:0] red;
        } chan;
    } pal_word_u;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888_t;

endpackage

`default_nettype wire

// File: hw/colmix_top.sv
// Colour mixer top level
`timescale 1ns/1ps
`default_nettype none

`include "colmix_settings.svh"

module colmix_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    input  logic                   lhbl,
    input  logic                   lvbl,
    input  colmix_pkg::layer_pxl_t lyr_fix,
    input  colmix_pkg::layer_pxl_t lyr_a,
    input  colmix_pkg::layer_pxl_t lyr_b,
    input  colmix_pkg::layer_pxl_t lyr_obj,
    input  logic [1:0]             prio_mode,
    input  logic                   crt_kill,
    input  colmix_pkg::cpu_bus_t   cpu,
    output logic [7:0]             cpu_din,
    output colmix_pkg::rgb888_t    rgb
);

    import colmix_pkg::*;

    mix_pxl_t                  mix;
    logic [`COLMIX_PAL_AW-1:0] vid_addr;
    logic [7:0]                vid_data;

    layer_prio i_layer_prio (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .lyr_fix   (lyr_fix),
        .lyr_a     (lyr_a),
        .lyr_b     (lyr_b),
        .lyr_obj   (lyr_obj),
        .prio_mode (prio_mode),
        .crt_kill  (crt_kill),
        .lhbl      (lhbl),
        .lvbl      (lvbl),
        .mix       (mix)
    );

    // CPU on port A, video fetch on port B
    pal_ram i_pal_ram (
        .clk      (clk),
        .cpu      (cpu),
        .cpu_din  (cpu_din),
        .vid_addr (vid_addr),
        .vid_data (vid_data)
    );

    colour_out i_colour_out (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .mix      (mix),
        .vid_addr (vid_addr),
        .vid_data (vid_data),
        .rgb      (rgb)
    );

endmodule

`default_nettype wire

// File: hw/colour_out.sv
// Palette fetch and colour output
`timescale 1ns/1ps
`default_nettype none

`include "colmix_settings.svh"

module colour_out (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  colmix_pkg::mix_pxl_t      mix,
    output logic [`COLMIX_PAL_AW-1:0] vid_addr,
    input  logic [7:0]                vid_data,
    output colmix_pkg::rgb888_t       rgb
);

    import colmix_pkg::*;

    localparam int PH_W = $clog2(`COLMIX_CEN_DIV);

    logic [PH_W-1:0] phase;
    logic            lo_sel;
    pal_word_u       word;
    logic            shadow_q;
    logic            visible_q;

    // 5 to 8 bit channel, shadow halves the level
    function automatic logic [7:0] expand(input logic [4:0] c, input logic shade);
        logic [7:0] res;
        if (shade) begin
            res = {1'b0, c, c[4:3]};
        end else begin
            res = {c, c[4:2]};
        end
        return res;
    endfunction

    // Clock count since the last pixel enable
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;
        end else if (pxl_cen) begin
            phase <= '0;
        end else begin
            phase <= phase + PH_W'(1);
        end
    end

    // High byte first, then low byte
    assign lo_sel   = phase == PH_W'(1);
    assign vid_addr = {mix.entry, lo_sel};

    // Bytes arrive one clock after their address
    always_ff @(posedge clk) begin
        word.bytes.hi <= word.bytes.lo;
        word.bytes.lo <= vid_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            shadow_q  <= 1'b0;
            visible_q <= 1'b0;
            rgb       <= '0;
        end else if (pxl_cen) begin
            // Flags follow the word being fetched
            shadow_q  <= mix.shadow;
            visible_q <= mix.visible;
            if (visible_q) begin
                rgb.red   <= expand(word.chan.red, shadow_q);
                rgb.green <= expand(word.chan.green, shadow_q);
                rgb.blue  <= expand(word.chan.blue, shadow_q);
            end else begin
                rgb <= '0;
            end
        end
    end

    // The two-byte fetch needs the full pixel period
    a_cen_spacing: assert property (
        @(posedge clk) disable iff (rst)
        pxl_cen |=> !pxl_cen [*(`COLMIX_CEN_DIV - 1)]
    );

endmodule

`default_nettype wire

// File: hw/layer_prio.sv
// Layer priority selection
`timescale 1ns/1ps
`default_nettype none

module layer_prio (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    input  colmix_pkg::layer_pxl_t lyr_fix,
    input  colmix_pkg::layer_pxl_t lyr_a,
    input  colmix_pkg::layer_pxl_t lyr_b,
    input  colmix_pkg::layer_pxl_t lyr_obj,
    input  logic [1:0]             prio_mode,
    input  logic                   crt_kill,
    input  logic                   lhbl,
    input  logic                   lvbl,
    output colmix_pkg::mix_pxl_t   mix
);

    import colmix_pkg::*;

    // Layer codes, also the top bits of the palette entry
    localparam logic [1:0] LYR_B   = 2'd0;
    localparam logic [1:0] LYR_A   = 2'd1;
    localparam logic [1:0] LYR_OBJ = 2'd2;
    localparam logic [1:0] LYR_FIX = 2'd3;

    // Search order per mode, first entry has the highest priority
    localparam logic [1:0] ORDER [4][4] = '{
        '{LYR_FIX, LYR_OBJ, LYR_A,   LYR_B  },
        '{LYR_FIX, LYR_A,   LYR_OBJ, LYR_B  },
        '{LYR_FIX, LYR_A,   LYR_B,   LYR_OBJ},
        '{LYR_FIX, LYR_OBJ, LYR_B,   LYR_A  }
    };

    logic [3:0] opaque;
    logic       obj_shadow;
    logic [3:0] sel;
    logic [1:0] win_code;
    layer_pxl_t win_pxl;
    mix_pxl_t   mix_nx;

    // Transparency per layer, objects with index 15 are shadows
    always_comb begin
        obj_shadow       = &lyr_obj.idx;
        opaque[LYR_FIX]  = |lyr_fix.idx;
        opaque[LYR_A]    = |lyr_a.idx;
        opaque[LYR_B]    = |lyr_b.idx;
        opaque[LYR_OBJ]  = |lyr_obj.idx & ~obj_shadow;
    end

    // First opaque layer in the mode order wins
    always_comb begin
        logic found;
        found = 1'b0;
        sel   = '0;
        for (int k = 0; k < 4; k++) begin
            if (!found && opaque[ORDER[prio_mode][k]]) begin
                sel[ORDER[prio_mode][k]] = 1'b1;
                found = 1'b1;
            end
        end
        // Nothing opaque, the back layer shows
        if (!(|opaque)) begin
            sel[LYR_B] = 1'b1;
        end
        if (crt_kill) begin
            sel = '0;
            sel[LYR_FIX] = 1'b1;
        end
    end

    always_comb begin
        if (sel[LYR_FIX]) begin
            win_code = LYR_FIX;
        end else if (sel[LYR_OBJ]) begin
            win_code = LYR_OBJ;
        end else if (sel[LYR_A]) begin
            win_code = LYR_A;
        end else begin
            win_code = LYR_B;
        end
        case (win_code)
            LYR_FIX: win_pxl = lyr_fix;
            LYR_OBJ: win_pxl = lyr_obj;
            LYR_A:   win_pxl = lyr_a;
            default: win_pxl = lyr_b;
        endcase
        mix_nx.entry   = {win_code, win_pxl};
        mix_nx.shadow  = obj_shadow & ~crt_kill;
        mix_nx.visible = lhbl & lvbl;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mix <= '0;
        end else if (pxl_cen) begin
            mix <= mix_nx;
        end
    end

    // One winner per pixel needs every layer in each mode order
    a_one_layer: assert property (
        @(posedge clk) disable iff (rst) pxl_cen |-> $onehot(sel)
    );

endmodule

`default_nettype wire

// File: hw/pal_ram.sv
// Dual-port palette RAM
`timescale 1ns/1ps
`default_nettype none

`include "colmix_settings.svh"

module pal_ram (
    input  logic                      clk,
    input  colmix_pkg::cpu_bus_t      cpu,
    output logic [7:0]                cpu_din,
    input  logic [`COLMIX_PAL_AW-1:0] vid_addr,
    output logic [7:0]                vid_data
);

    localparam int DEPTH = 2 ** `COLMIX_PAL_AW;

    logic [7:0] mem [DEPTH];

    // CPU port, read returns the old byte during a write
    always_ff @(posedge clk) begin
        if (cpu.we) begin
            mem[cpu.addr] <= cpu.data;
        end
        cpu_din <= mem[cpu.addr];
    end

    // Video port, read only
    always_ff @(posedge clk) begin
        vid_data <= mem[vid_addr];
    end

    // A write to an unknown address would corrupt arbitrary entries
    a_cpu_addr_known: assert property (
        @(posedge clk) cpu.we |-> !$isunknown(cpu.addr)
    );

endmodule

`default_nettype wire

// File: include/colmix_settings.svh
// Colour mixer build settings

`ifndef COLMIX_SETTINGS_SVH
`define COLMIX_SETTINGS_SVH

// Palette byte address width
// 1024 entries of two bytes each
`define COLMIX_PAL_AW 11

// Clocks per pixel
// The palette fetch takes two clocks, one per byte
`define COLMIX_CEN_DIV 2

`endif

// File: tb/colmix_clkgen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module colmix_clkgen #(
    parameter int PERIOD_NS  = 4,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Reset drops just after a rising edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb/colmix_input.txt
# Kinds: T test number, W addr data, R addr expected_data, P pixel
# P columns: fix a b obj mode kill lhbl lvbl expected_rgb, all hex
T 1
W 624 00
W 625 1f
W 446 03
W 447 e0
W 268 7c
W 269 00
W 08a 11
W 08b 10
W 080 30
W 081 c3
W 620 62
W 621 08
R 625 1f
R 446 03
R 620 62
T 2
P 12 34 45 23 0 0 1 1 ff0000
P 10 34 45 23 0 0 1 1 00ff00
P 10 34 45 20 0 0 1 1 0000ff
P 10 30 40 20 0 0 1 1 183163
P 10 30 45 23 1 0 1 1 00ff00
P 10 34 45 23 1 0 1 1 0000ff
P 10 30 45 23 2 0 1 1 844221
P 10 30 40 23 2 0 1 1 00ff00
P 10 34 45 20 3 0 1 1 844221
P 10 34 40 20 3 0 1 1 0000ff
T 3
P 10 34 45 2f 0 0 1 1 00007f
P 12 34 45 2f 1 0 1 1 7f0000
P 10 30 45 2f 2 0 1 1 422110
T 4
P 12 34 45 2f 2 1 1 1 ff0000
P 10 34 45 23 0 1 1 1 4284c6
P 10 30 45 2f 3 1 1 1 4284c6
T 5
P 10 30 45 20 0 0 1 1 844221
P 10 30 45 20 0 0 0 1 000000
P 10 30 45 20 0 0 1 1 844221
P 10 30 45 20 0 0 1 0 000000
T 6
P 10 30 45 20 0 0 1 1 844221
W 08a 7f
W 08b ff
P 10 30 45 20 0 0 1 1 ffffff
P 10 34 45 20 0 0 1 1 0000ff
R 08b ff

// File: tb/tb_colmix.sv
// Colour mixer testbench
`timescale 1ns/1ps
`default_nettype none

`include "colmix_settings.svh"

module tb_colmix;

    import colmix_pkg::*;

    localparam int CLK_NS  = 4;
    localparam int MAX_REC = 256;

    logic       clk;
    logic       rst;
    logic       pxl_cen;
    logic       lhbl;
    logic       lvbl;
    layer_pxl_t lyr_fix;
    layer_pxl_t lyr_a;
    layer_pxl_t lyr_b;
    layer_pxl_t lyr_obj;
    logic [1:0] prio_mode;
    logic       crt_kill;
    cpu_bus_t   cpu;
    logic [7:0] cpu_din;
    rgb888_t    rgb;

    // Records from the stimulus file
    logic [7:0]  rec_kind [MAX_REC];
    logic [23:0] rec_fld [MAX_REC][9];
    int          n_rec;
    logic        loaded;

    // Expected colours of the two pixels in flight
    logic        pipe_v [2];
    logic [23:0] pipe_exp [2];
    int          pipe_rec [2];
    logic        cur_v;
    logic [23:0] cur_exp;
    int          cur_rec;
    int          cen_cnt;

    int test_num;
    int n_tests;
    int n_checks;
    int n_err;
    int t_checks;
    int t_err;

    colmix_clkgen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(5)) i_clkgen (.clk(clk), .rst(rst));

    colmix_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .lhbl      (lhbl),
        .lvbl      (lvbl),
        .lyr_fix   (lyr_fix),
        .lyr_a     (lyr_a),
        .lyr_b     (lyr_b),
        .lyr_obj   (lyr_obj),
        .prio_mode (prio_mode),
        .crt_kill  (crt_kill),
        .cpu       (cpu),
        .cpu_din   (cpu_din),
        .rgb       (rgb)
    );

    function automatic int field_count(input logic [7:0] kind);
        case (kind)
            "T": return 1;
            "P": return 9;
            default: return 2;
        endcase
    endfunction

    task automatic load_records();
        int          fd;
        int          c;
        logic [7:0]  kind;
        logic [23:0] val;
        fd = $fopen("tb/colmix_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/colmix_input.txt");
            n_err++;
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                if (kind == "#") begin
                    c = $fgetc(fd);
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else begin
                    rec_kind[n_rec] = kind;
                    for (int k = 0; k < field_count(kind); k++) begin
                        c = $fscanf(fd, "%h", val);
                        rec_fld[n_rec][k] = val;
                    end
                    n_rec++;
                end
            end
            $fclose(fd);
        end
    endtask

    // One clock; at a pixel enable the oldest pixel in flight is checked
    task automatic advance_clock();
        logic at_cen;
        at_cen = pxl_cen;
        @(posedge clk);
        #1;
        if (at_cen) begin
            if (pipe_v[1]) begin
                n_checks++;
                t_checks++;
                if (rgb !== pipe_exp[1]) begin
                    $display("error: rgb at record %0d is %h, expected %h",
                             pipe_rec[1], rgb, pipe_exp[1]);
                    n_err++;
                    t_err++;
                end
            end
            pipe_v[1]   = pipe_v[0];
            pipe_exp[1] = pipe_exp[0];
            pipe_rec[1] = pipe_rec[0];
            pipe_v[0]   = cur_v;
            pipe_exp[0] = cur_exp;
            pipe_rec[0] = cur_rec;
            cur_v       = 1'b0;
        end
        cen_cnt = (cen_cnt + 1) % `COLMIX_CEN_DIV;
        pxl_cen = (cen_cnt == 0);
    endtask

    task automatic finish_test();
        while (pipe_v[0] || pipe_v[1]) begin
            advance_clock();
        end
        $display("test %0d: %0d checks, %0d errors", test_num, t_checks, t_err);
        n_tests++;
        t_checks = 0;
        t_err    = 0;
    endtask

    initial begin
        pxl_cen   = 1'b0;
        lhbl      = 1'b0;
        lvbl      = 1'b0;
        lyr_fix   = '0;
        lyr_a     = '0;
        lyr_b     = '0;
        lyr_obj   = '0;
        prio_mode = 2'd0;
        crt_kill  = 1'b0;
        cpu       = '0;
        loaded    = 1'b0;
        n_rec     = 0;
        cur_v     = 1'b0;
        cur_exp   = '0;
        cur_rec   = 0;
        test_num  = 0;
        n_tests   = 0;
        n_checks  = 0;
        n_err     = 0;
        t_checks  = 0;
        t_err     = 0;
        load_records();
        loaded = 1'b1;
        wait (rst == 1'b0);
        // Two black pixels come out of the reset state
        pipe_v[0]   = 1'b1;
        pipe_v[1]   = 1'b1;
        pipe_exp[0] = '0;
        pipe_exp[1] = '0;
        pipe_rec[0] = 0;
        pipe_rec[1] = 0;
        cen_cnt     = 0;
        pxl_cen     = 1'b1;
        for (int i = 0; i < n_rec; i++) begin
            case (rec_kind[i])
                "T": begin
                    if (test_num > 0) begin
                        finish_test();
                    end
                    test_num = int'(rec_fld[i][0]);
                end
                "W": begin
                    // Writes land on a pixel enable, after the last fetch
                    while (!pxl_cen) begin
                        advance_clock();
                    end
                    cpu.we   = 1'b1;
                    cpu.addr = rec_fld[i][0][`COLMIX_PAL_AW-1:0];
                    cpu.data = rec_fld[i][1][7:0];
                    advance_clock();
                    cpu.we   = 1'b0;
                end
                "R": begin
                    cpu.addr = rec_fld[i][0][`COLMIX_PAL_AW-1:0];
                    advance_clock();
                    n_checks++;
                    t_checks++;
                    if (cpu_din !== rec_fld[i][1][7:0]) begin
                        $display("error: cpu_din at record %0d (addr %h) is %h, expected %h",
                                 i + 1, cpu.addr, cpu_din, rec_fld[i][1][7:0]);
                        n_err++;
                        t_err++;
                    end
                end
                "P": begin
                    while (!pxl_cen) begin
                        advance_clock();
                    end
                    lyr_fix   = rec_fld[i][0][7:0];
                    lyr_a     = rec_fld[i][1][7:0];
                    lyr_b     = rec_fld[i][2][7:0];
                    lyr_obj   = rec_fld[i][3][7:0];
                    prio_mode = rec_fld[i][4][1:0];
                    crt_kill  = rec_fld[i][5][0];
                    lhbl      = rec_fld[i][6][0];
                    lvbl      = rec_fld[i][7][0];
                    cur_v     = 1'b1;
                    cur_exp   = rec_fld[i][8];
                    cur_rec   = i + 1;
                    advance_clock();
                end
                default: begin
                    $display("record %0d has an unknown kind", i + 1);
                    n_err++;
                end
            endcase
        end
        finish_test();
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_err);
        if (n_err == 0 && n_checks > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the record count
    initial begin
        wait (loaded);
        #((n_rec * 8 + 200) * CLK_NS);
        $display("run timed out after %0d clocks", n_rec * 8 + 200);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
hw/colmix_pkg.sv
hw/layer_prio.sv
hw/pal_ram.sv
hw/colour_out.sv
hw/colmix_top.sv
tb/colmix_clkgen.sv
tb/tb_colmix.sv
